// File: rtl/frv_pkg.sv
/*
 * Widths, RV32I opcodes and the payload structs shared by the pipeline
 * stages, the memory arbiter and the testbench. Referenced by scoped name.
 */
`default_nettype none

package frv_pkg;

    // ----------------------------------------
    // Widths
    // ----------------------------------------
    localparam int XLEN   = 32;                     // Data and address width
    localparam int NREG   = 32;                     // Architectural registers
    localparam int REG_AW = $clog2(NREG);           // Register index width

    // ----------------------------------------
    // Encodings
    // ----------------------------------------
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011; // ADDI
    localparam logic [6:0] OPC_OP     = 7'b0110011; // ADD, SUB
    localparam logic [6:0] OPC_LOAD   = 7'b0000011; // LW
    localparam logic [6:0] OPC_STORE  = 7'b0100011; // SW
    localparam logic [6:0] FUNCT7_SUB = 7'b0100000; // Picks SUB inside OPC_OP

    typedef enum logic [2:0] {
        NOP,                                        // Retires, writes nothing
        ADD,
        SUB,
        LOAD,
        STORE
    } uop_t;

    typedef struct packed {
        logic            wen;                       // Write when set
        logic [3:0]      strb;                      // Byte strobes
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] wdata;
    } mem_req_t;

    // Decode to execute
    typedef struct packed {
        logic [REG_AW-1:0] rd;                      // Zero when nothing written
        uop_t              uop;
        logic [XLEN-1:0]   opr_a;                   // rs1
        logic [XLEN-1:0]   opr_b;                   // rs2 or immediate
        logic [XLEN-1:0]   opr_c;                   // Store data
    } ex_t;

    // Execute to memory
    typedef struct packed {
        logic [REG_AW-1:0] rd;
        uop_t              uop;
        logic [XLEN-1:0]   result;                  // ALU result or address
        logic [XLEN-1:0]   wdata;                   // Store data
    } mem_t;

    typedef struct packed {
        logic              valid;
        logic [REG_AW-1:0] rd;
        logic [XLEN-1:0]   wdata;
        logic              load;                    // wdata not known yet
    } fwd_t;

    typedef struct packed {
        logic              wen;
        logic [REG_AW-1:0] rd;
        logic [XLEN-1:0]   wdata;
    } gpr_wr_t;

endpackage

`default_nettype wire

// File: rtl/frv_fetch.sv
/*
 * Fetch stage. Reads one instruction word at a time over its arbiter
 * port and keeps it in a one-entry buffer until decode takes it.
 */
`timescale 1ns/1ns
`default_nettype none

module frv_fetch #(
    parameter logic [frv_pkg::XLEN-1:0] PC_RESET_VALUE = 32'h8000_0000
) (
    input  wire                     g_clk,
    input  wire                     rst,
    output logic                    bus_req,        // Read request
    output frv_pkg::mem_req_t       bus_out,
    input  wire                     bus_gnt,
    input  wire                     bus_rvalid,     // Read data strobe
    input  wire [frv_pkg::XLEN-1:0] bus_rdata,
    output logic                    s1_valid,
    output logic [31:0]             s1_instr,
    input  wire                     s1_busy
);

    logic                     running;              // Low in the reset cycle
    logic                     rd_pend;              // Granted, data not back
    logic                     buf_valid;
    logic [31:0]              buf_instr;
    logic [frv_pkg::XLEN-1:0] pc;

    // Ask only with nothing in flight and room in the buffer
    assign bus_req  = running && !rd_pend && !buf_valid;
    assign bus_out  = '{wen: 1'b0, strb: 4'b0000, addr: pc, wdata: '0};
    assign s1_valid = buf_valid;
    assign s1_instr = buf_instr;

    always_ff @(posedge g_clk) begin
        if (rst) begin
            running   <= 1'b0;
            rd_pend   <= 1'b0;
            buf_valid <= 1'b0;
            pc        <= PC_RESET_VALUE;
        end else begin
            running <= 1'b1;
            if (bus_req && bus_gnt) begin
                rd_pend <= 1'b1;
            end else if (bus_rvalid) begin
                rd_pend <= 1'b0;
            end
            if (bus_rvalid) begin
                buf_valid <= 1'b1;
                pc        <= pc + 32'd4;            // Next word
            end else if (!s1_busy) begin
                buf_valid <= 1'b0;                  // Decode took it
            end
        end
    end

    always_ff @(posedge g_clk) begin
        if (bus_rvalid) begin
            buf_instr <= bus_rdata;
        end
    end

    // Address must not move under an ungranted request
    assert property (@(posedge g_clk) disable iff (rst)
        bus_req && !bus_gnt |=> bus_req && $stable(bus_out.addr))
        else $error("fetch address moved before grant");

endmodule

`default_nettype wire

// File: rtl/frv_decode.sv
/*
 * Decode stage. Turns ADDI, ADD, SUB, LW and SW into micro-ops, reads
 * and forwards source operands, and holds a bubble on a load-use hazard.
 */
`timescale 1ns/1ns
`default_nettype none

module frv_decode (
    input  wire                         g_clk,
    input  wire                         rst,
    input  wire                         s1_valid,
    input  wire [31:0]                  s1_instr,
    output logic                        s1_busy,
    output logic [frv_pkg::REG_AW-1:0]  rs1_addr,
    output logic [frv_pkg::REG_AW-1:0]  rs2_addr,
    input  wire [frv_pkg::XLEN-1:0]     rs1_rdata,
    input  wire [frv_pkg::XLEN-1:0]     rs2_rdata,
    input  wire frv_pkg::fwd_t          fwd_s2,     // From execute
    input  wire frv_pkg::fwd_t          fwd_s3,     // From memory
    input  wire frv_pkg::gpr_wr_t       gpr_wr,     // From writeback
    output logic                        s2_valid,
    output frv_pkg::ex_t                s2_data,
    input  wire                         s2_busy
);

    logic [6:0]               opcode;
    logic [2:0]               funct3;
    logic [6:0]               funct7;
    logic [frv_pkg::XLEN-1:0] imm_i;
    logic [frv_pkg::XLEN-1:0] imm_s;
    frv_pkg::uop_t            uop;
    logic                     writes_rd;
    logic                     use_rs2;              // ADD, SUB, SW
    logic [frv_pkg::XLEN-1:0] rs1_val;              // After forwarding
    logic [frv_pkg::XLEN-1:0] rs2_val;
    logic [frv_pkg::XLEN-1:0] opr_b;
    logic                     stall_rs1;
    logic                     stall_rs2;
    logic                     bubble;
    logic                     s2_free;

    // Youngest producer wins; top bit flags a load still in flight
    function automatic logic [frv_pkg::XLEN:0] bypass(
        input logic [frv_pkg::REG_AW-1:0] ra,
        input logic [frv_pkg::XLEN-1:0]   rf,
        input frv_pkg::fwd_t              f2,
        input frv_pkg::fwd_t              f3,
        input frv_pkg::gpr_wr_t           wb
    );
        if (ra == '0) begin
            return {1'b0, rf};                      // x0 never forwards
        end else if (f2.valid && f2.rd == ra) begin
            return {f2.load, f2.wdata};
        end else if (f3.valid && f3.rd == ra) begin
            return {f3.load, f3.wdata};
        end else if (wb.wen && wb.rd == ra) begin
            return {1'b0, wb.wdata};
        end
        return {1'b0, rf};
    endfunction

    assign opcode   = s1_instr[6:0];
    assign funct3   = s1_instr[14:12];
    assign funct7   = s1_instr[31:25];
    assign rs1_addr = s1_instr[19:15];
    assign rs2_addr = s1_instr[24:20];
    assign imm_i    = {{20{s1_instr[31]}}, s1_instr[31:20]};
    assign imm_s    = {{20{s1_instr[31]}}, s1_instr[31:25], s1_instr[11:7]};

    always_comb begin
        uop = frv_pkg::NOP;                         // Anything unknown
        if (opcode == frv_pkg::OPC_OP_IMM && funct3 == 3'b000) begin
            uop = frv_pkg::ADD;
        end else if (opcode == frv_pkg::OPC_OP && funct3 == 3'b000) begin
            if (funct7 == 7'b0000000) begin
                uop = frv_pkg::ADD;
            end else if (funct7 == frv_pkg::FUNCT7_SUB) begin
                uop = frv_pkg::SUB;
            end
        end else if (opcode == frv_pkg::OPC_LOAD && funct3 == 3'b010) begin
            uop = frv_pkg::LOAD;
        end else if (opcode == frv_pkg::OPC_STORE && funct3 == 3'b010) begin
            uop = frv_pkg::STORE;
        end
    end

    assign writes_rd = uop inside {frv_pkg::ADD, frv_pkg::SUB, frv_pkg::LOAD};
    assign use_rs2   = uop != frv_pkg::NOP &&
                       (opcode == frv_pkg::OPC_OP || opcode == frv_pkg::OPC_STORE);

    assign {stall_rs1, rs1_val} = bypass(rs1_addr, rs1_rdata, fwd_s2, fwd_s3, gpr_wr);
    assign {stall_rs2, rs2_val} = bypass(rs2_addr, rs2_rdata, fwd_s2, fwd_s3, gpr_wr);

    always_comb begin
        case (opcode)
            frv_pkg::OPC_OP:    opr_b = rs2_val;
            frv_pkg::OPC_STORE: opr_b = imm_s;      // Address offset
            default:            opr_b = imm_i;
        endcase
    end

    assign bubble  = s1_valid && ((stall_rs1 && uop != frv_pkg::NOP) ||
                                  (stall_rs2 && use_rs2));
    assign s2_free = !s2_valid || !s2_busy;
    assign s1_busy = !s2_free || bubble;

    always_ff @(posedge g_clk) begin
        if (rst) begin
            s2_valid <= 1'b0;
        end else if (s2_free) begin
            s2_valid <= s1_valid && !bubble;
        end
    end

    always_ff @(posedge g_clk) begin
        if (s2_free) begin
            s2_data.rd    <= writes_rd ? s1_instr[11:7] : '0;
            s2_data.uop   <= uop;
            s2_data.opr_a <= rs1_val;
            s2_data.opr_b <= opr_b;
            s2_data.opr_c <= rs2_val;               // SW data
        end
    end

endmodule

`default_nettype wire

// File: rtl/frv_execute.sv
/*
 * Execute stage. One adder covers ADD, SUB and the load/store address;
 * the result is offered for forwarding and registered into the memory stage.
 */
`timescale 1ns/1ns
`default_nettype none

module frv_execute (
    input  wire                  g_clk,
    input  wire                  rst,
    input  wire                  s2_valid,
    input  wire frv_pkg::ex_t    s2_data,
    output logic                 s2_busy,
    output frv_pkg::fwd_t        fwd_s2,
    output logic                 s3_valid,
    output frv_pkg::mem_t        s3_data,
    input  wire                  s3_busy
);

    logic [frv_pkg::XLEN-1:0] result;
    logic                     s3_free;

    assign result  = (s2_data.uop == frv_pkg::SUB) ? s2_data.opr_a - s2_data.opr_b :
                                                     s2_data.opr_a + s2_data.opr_b;
    assign s3_free = !s3_valid || !s3_busy;
    assign s2_busy = !s3_free;                      // Held while memory stalls

    assign fwd_s2 = '{valid: s2_valid, rd: s2_data.rd, wdata: result,
                      load: s2_data.uop == frv_pkg::LOAD};

    always_ff @(posedge g_clk) begin
        if (rst) begin
            s3_valid <= 1'b0;
        end else if (s3_free) begin
            s3_valid <= s2_valid;
        end
    end

    always_ff @(posedge g_clk) begin
        if (s3_free) begin
            s3_data.rd     <= s2_data.rd;
            s3_data.uop    <= s2_data.uop;
            s3_data.result <= result;
            s3_data.wdata  <= s2_data.opr_c;
        end
    end

endmodule

`default_nettype wire

// File: rtl/frv_memory.sv
/*
 * Memory stage and writeback register. Issues word loads and stores on
 * its arbiter port, then drives the register write and the retire pulse.
 */
`timescale 1ns/1ns
`default_nettype none

module frv_memory (
    input  wire                     g_clk,
    input  wire                     rst,
    input  wire                     s3_valid,
    input  wire frv_pkg::mem_t      s3_data,
    output logic                    s3_busy,
    output logic                    bus_req,
    output frv_pkg::mem_req_t       bus_out,
    input  wire                     bus_gnt,
    input  wire                     bus_rvalid,     // Load data strobe
    input  wire [frv_pkg::XLEN-1:0] bus_rdata,
    output frv_pkg::fwd_t           fwd_s3,
    output frv_pkg::gpr_wr_t        gpr_wr,
    output logic                    instr_ret
);

    logic                       is_load;
    logic                       is_store;
    logic                       ld_wait;            // Load granted, data due
    logic                       done;               // Item leaves this cycle
    logic                       wb_valid;
    logic [frv_pkg::REG_AW-1:0] wb_rd;
    logic [frv_pkg::XLEN-1:0]   wb_data;

    assign is_load  = s3_data.uop == frv_pkg::LOAD;
    assign is_store = s3_data.uop == frv_pkg::STORE;

    assign bus_req = s3_valid && (is_load || is_store) && !ld_wait;
    assign bus_out = '{wen: is_store, strb: {4{is_store}}, addr: s3_data.result,
                       wdata: s3_data.wdata};

    always_comb begin
        if (is_load) begin
            done = ld_wait && bus_rvalid;
        end else if (is_store) begin
            done = bus_req && bus_gnt;              // Store ends on grant
        end else begin
            done = 1'b1;
        end
    end

    assign s3_busy = s3_valid && !done;
    assign fwd_s3  = '{valid: s3_valid, rd: s3_data.rd, wdata: s3_data.result,
                       load: is_load};
    assign gpr_wr  = '{wen: wb_valid, rd: wb_rd, wdata: wb_data};

    always_ff @(posedge g_clk) begin
        if (rst) begin
            ld_wait   <= 1'b0;
            wb_valid  <= 1'b0;
            instr_ret <= 1'b0;
        end else begin
            if (bus_req && bus_gnt && is_load) begin
                ld_wait <= 1'b1;
            end else if (bus_rvalid) begin
                ld_wait <= 1'b0;
            end
            wb_valid  <= s3_valid && done;
            instr_ret <= wb_valid;                  // One pulse per retirement
        end
    end

    always_ff @(posedge g_clk) begin
        if (s3_valid && done) begin
            wb_rd   <= s3_data.rd;
            wb_data <= is_load ? bus_rdata : s3_data.result;
        end
    end

    // A granted load gets its data next cycle, with no request meanwhile
    assert property (@(posedge g_clk) disable iff (rst)
        bus_req && bus_gnt && is_load |=> bus_rvalid && !bus_req)
        else $error("memory stage request while load data pending");

endmodule

`default_nettype wire

// File: rtl/frv_gprs.sv
/*
 * General purpose register file. Two combinational read ports and one
 * write port; x0 reads as zero and ignores writes.
 */
`timescale 1ns/1ns
`default_nettype none

module frv_gprs (
    input  wire                        g_clk,
    input  wire                        rst,
    input  wire [frv_pkg::REG_AW-1:0]  rs1_addr,
    input  wire [frv_pkg::REG_AW-1:0]  rs2_addr,
    input  wire frv_pkg::gpr_wr_t      gpr_wr,
    output logic [frv_pkg::XLEN-1:0]   rs1_rdata,
    output logic [frv_pkg::XLEN-1:0]   rs2_rdata
);

    logic [frv_pkg::XLEN-1:0] regs [1:frv_pkg::NREG-1];    // No storage for x0

    assign rs1_rdata = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_rdata = (rs2_addr == '0) ? '0 : regs[rs2_addr];

    always_ff @(posedge g_clk) begin
        if (!rst && gpr_wr.wen && gpr_wr.rd != '0) begin
            regs[gpr_wr.rd] <= gpr_wr.wdata;
        end
    end

endmodule

`default_nettype wire

// File: rtl/frv_mem_arbiter.sv
/*
 * Shares the single memory bus between the memory stage (port 0, higher
 * priority) and fetch (port 1). Routes read data back to the owner.
 */
`timescale 1ns/1ns
`default_nettype none

module frv_mem_arbiter (
    input  wire                      g_clk,
    input  wire                      rst,
    input  wire                      m0_req,        // Memory stage
    input  wire frv_pkg::mem_req_t   m0_out,
    output logic                     m0_gnt,
    output logic                     m0_rvalid,
    input  wire                      m1_req,        // Fetch
    input  wire frv_pkg::mem_req_t   m1_out,
    output logic                     m1_gnt,
    output logic                     m1_rvalid,
    output logic [frv_pkg::XLEN-1:0] rdata,
    output logic                     mem_req,
    output frv_pkg::mem_req_t        mem_out,
    input  wire                      mem_gnt,
    input  wire [frv_pkg::XLEN-1:0]  mem_rdata
);

    logic sel_m0;
    logic hold;                                     // Ungranted request on bus
    logic hold_m0;                                  // Whose request that was

    // Priority to m0 unless a request is already waiting
    assign sel_m0  = hold ? hold_m0 : m0_req;
    assign mem_req = sel_m0 ? m0_req : m1_req;
    assign mem_out = sel_m0 ? m0_out : m1_out;
    assign m0_gnt  = sel_m0 && m0_req && mem_gnt;
    assign m1_gnt  = !sel_m0 && m1_req && mem_gnt;
    assign rdata   = mem_rdata;

    always_ff @(posedge g_clk) begin
        if (rst) begin
            hold      <= 1'b0;
            hold_m0   <= 1'b0;
            m0_rvalid <= 1'b0;
            m1_rvalid <= 1'b0;
        end else begin
            hold      <= mem_req && !mem_gnt;
            hold_m0   <= sel_m0;
            m0_rvalid <= m0_gnt && !m0_out.wen;     // Read data due next cycle
            m1_rvalid <= m1_gnt && !m1_out.wen;
        end
    end

    assert property (@(posedge g_clk) disable iff (rst) !(m0_gnt && m1_gnt))
        else $error("both masters granted");

    // Bus request stays put until granted, whichever master owns it
    assert property (@(posedge g_clk) disable iff (rst)
        mem_req && !mem_gnt |=> mem_req && $stable(mem_out))
        else $error("bus request changed before grant");

endmodule

`default_nettype wire

// File: rtl/frv_pipeline.sv
/*
 * Top level of the five-stage core. Wires fetch, decode, execute, memory
 * and the register file together, with one arbitrated memory bus out.
 */
`timescale 1ns/1ns
`default_nettype none

module frv_pipeline #(
    parameter logic [frv_pkg::XLEN-1:0] PC_RESET_VALUE = 32'h8000_0000
) (
    input  wire                     g_clk,
    input  wire                     rst,
    output logic                    mem_req,
    output frv_pkg::mem_req_t       mem_out,
    input  wire                     mem_gnt,
    input  wire [frv_pkg::XLEN-1:0] mem_rdata,
    output logic                    instr_ret       // One pulse per retirement
);

    // ----------------------------------------
    // Bus masters
    // ----------------------------------------
    logic                       fetch_req;
    frv_pkg::mem_req_t          fetch_out;
    logic                       fetch_gnt;
    logic                       fetch_rvalid;
    logic                       lsu_req;
    frv_pkg::mem_req_t          lsu_out;
    logic                       lsu_gnt;
    logic                       lsu_rvalid;
    logic [frv_pkg::XLEN-1:0]   bus_rdata;          // Shared read data

    // ----------------------------------------
    // Stage links
    // ----------------------------------------
    logic                       s1_valid;
    logic                       s1_busy;
    logic [31:0]                s1_instr;
    logic [frv_pkg::REG_AW-1:0] rs1_addr;
    logic [frv_pkg::REG_AW-1:0] rs2_addr;
    logic [frv_pkg::XLEN-1:0]   rs1_rdata;
    logic [frv_pkg::XLEN-1:0]   rs2_rdata;
    logic                       s2_valid;
    logic                       s2_busy;
    frv_pkg::ex_t               s2_data;
    frv_pkg::fwd_t              fwd_s2;
    frv_pkg::fwd_t              fwd_s3;
    logic                       s3_valid;
    logic                       s3_busy;
    frv_pkg::mem_t              s3_data;
    frv_pkg::gpr_wr_t           gpr_wr;

    frv_fetch #(
        .PC_RESET_VALUE(PC_RESET_VALUE)
    ) i_fetch (
        .bus_req    (fetch_req   ),
        .bus_out    (fetch_out   ),
        .bus_gnt    (fetch_gnt   ),
        .bus_rvalid (fetch_rvalid),
        .*
    );

    frv_decode i_decode (.*);

    frv_execute i_execute (.*);

    frv_memory i_memory (
        .bus_req    (lsu_req     ),
        .bus_out    (lsu_out     ),
        .bus_gnt    (lsu_gnt     ),
        .bus_rvalid (lsu_rvalid  ),
        .*
    );

    frv_gprs i_gprs (.*);

    frv_mem_arbiter i_arbiter (
        .m0_req     (lsu_req     ),                 // Memory stage first
        .m0_out     (lsu_out     ),
        .m0_gnt     (lsu_gnt     ),
        .m0_rvalid  (lsu_rvalid  ),
        .m1_req     (fetch_req   ),
        .m1_out     (fetch_out   ),
        .m1_gnt     (fetch_gnt   ),
        .m1_rvalid  (fetch_rvalid),
        .rdata      (bus_rdata   ),
        .*
    );

endmodule

`default_nettype wire

// File: tb/frv_pipeline_tb.sv
/*
 * Testbench for the five-stage core. Builds a random ADDI/ADD/SUB/LW/SW
 * program in a word memory model, runs a reference model over it in
 * program order, and checks fetch order, bus stability, stores and retires.
 */
`timescale 1ns/1ns
`default_nettype none

module frv_pipeline_tb;

    localparam logic [31:0] PC_RESET  = 32'h8000_0000;  // DUT default
    localparam logic [31:0] DATA_BASE = 32'h0000_1000;
    localparam logic [31:0] NOP_WORD  = 32'h0000_0013;  // addi x0, x0, 0
    localparam int          PROG_LEN  = 60;
    localparam int          TIMEOUT   = 5000;
    localparam int KIND_ADDI = 0;
    localparam int KIND_ADD  = 1;
    localparam int KIND_SUB  = 2;
    localparam int KIND_LW   = 3;
    localparam int KIND_SW   = 4;
    localparam int KIND_BAD  = 5;                       // Not in the subset

    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] index;                             // Position in program
    } store_t;

    logic              g_clk;
    logic              rst;
    logic              mem_req;
    frv_pkg::mem_req_t mem_out;
    logic              mem_gnt;
    logic [31:0]       mem_rdata;
    logic              instr_ret;

    integer      seed;
    logic [31:0] mem [logic [31:0]];                    // DUT side memory
    logic [31:0] ref_dmem [logic [31:0]];               // Reference data memory
    logic [31:0] xr [0:7];                              // Reference x0..x7
    store_t      exp_stores [$];
    store_t      head;
    int          prog_len;
    int          retired;
    int          cycles;
    logic        rd_due;                                // Read data owed next cycle
    logic [31:0] rd_addr;
    logic [31:0] next_fetch;

    frv_pipeline frv_pipeline_i (
        .g_clk     (g_clk),
        .rst       (rst),
        .mem_req   (mem_req),
        .mem_out   (mem_out),
        .mem_gnt   (mem_gnt),
        .mem_rdata (mem_rdata),
        .instr_ret (instr_ret)
    );

    initial begin
        g_clk = 1'b0;
        forever #20 g_clk = ~g_clk;
    end

    // ----------------------------------------
    // Failure reporting and helpers
    // ----------------------------------------
    task automatic fail_run();
        $display("Result: FAILED");
        $fatal(1);
    endtask

    task automatic show_mismatch(input string test, input logic [31:0] expected,
                                 input logic [31:0] actual);
        $display("ERR %s: expected %h, actual %h", test, expected, actual);
        fail_run();
    endtask

    task automatic report_problem(input string what);
        $display("%s", what);
        fail_run();
    endtask

    function automatic int pick_below(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    // Unwritten data words differ at every address
    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return addr ^ {addr[15:0], addr[31:16]} ^ 32'h9e37_79b9;
    endfunction

    function automatic logic [31:0] read_word(input logic [31:0] addr);
        if (mem.exists(addr)) begin
            return mem[addr];
        end else if (addr >= PC_RESET) begin
            return NOP_WORD;                            // Endless no-op tail
        end
        return fill_word(addr);
    endfunction

    // Encode one instruction into memory and run it on the reference model
    task automatic append_instr(input int kind, input int rd, input int rs1,
                                input int rs2, input logic [11:0] imm);
        logic [31:0] word;
        logic [31:0] imm_x;
        logic [31:0] addr;
        store_t      st;
        imm_x = {{20{imm[11]}}, imm};                   // Sign extended
        addr  = xr[rs1] + imm_x;
        case (kind)
            KIND_ADDI: begin
                word   = {imm, rs1[4:0], 3'b000, rd[4:0], 7'b0010011};
                xr[rd] = xr[rs1] + imm_x;
            end
            KIND_ADD: begin
                word   = {7'b0000000, rs2[4:0], rs1[4:0], 3'b000, rd[4:0], 7'b0110011};
                xr[rd] = xr[rs1] + xr[rs2];
            end
            KIND_SUB: begin
                word   = {7'b0100000, rs2[4:0], rs1[4:0], 3'b000, rd[4:0], 7'b0110011};
                xr[rd] = xr[rs1] - xr[rs2];
            end
            KIND_LW: begin
                word   = {imm, rs1[4:0], 3'b010, rd[4:0], 7'b0000011};
                xr[rd] = ref_dmem.exists(addr) ? ref_dmem[addr] : fill_word(addr);
            end
            KIND_SW: begin
                word  = {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
                st    = '{addr: addr, data: xr[rs2], index: prog_len};
                ref_dmem[addr] = xr[rs2];
                exp_stores.push_back(st);
            end
            default: begin                              // XORI or LUI shape, no effect
                if (rs2 % 2 == 0) begin
                    word = {imm, rs1[4:0], 3'b100, rd[4:0], 7'b0010011};
                end else begin
                    word = {imm, rs1[4:0], 3'b000, rd[4:0], 7'b0110111};
                end
            end
        endcase
        xr[0] = '0;
        mem[PC_RESET + 32'(4 * prog_len)] = word;
        prog_len++;
    endtask

    task automatic build_program();
        int choice;
        int rd;
        int rs1;
        int rs2;
        logic [11:0] off;
        for (int i = 0; i < 8; i++) begin
            xr[i] = '0;
        end
        append_instr(KIND_ADDI, 1, 0, 0, 12'h7ff);      // x1 becomes DATA_BASE
        append_instr(KIND_ADDI, 1, 1, 0, 12'h7ff);
        append_instr(KIND_ADDI, 1, 1, 0, 12'h002);
        for (int r = 2; r < 8; r++) begin
            append_instr(KIND_ADDI, r, 0, 0, 12'($random(seed)));   // Register file starts unknown
        end
        while (prog_len < PROG_LEN - 1) begin
            choice = pick_below(16);
            rd     = 2 + pick_below(6);                 // x1 stays the base
            rs1    = pick_below(8);
            rs2    = pick_below(8);
            off    = 12'(4 * pick_below(16));
            if (choice < 4) begin
                append_instr(KIND_ADDI, rd, rs1, 0, 12'($random(seed)));
            end else if (choice < 6) begin
                append_instr(KIND_ADD, rd, rs1, rs2, '0);
            end else if (choice < 8) begin
                append_instr(KIND_SUB, rd, rs1, rs2, '0);
            end else if (choice < 10) begin
                append_instr(KIND_LW, rd, 1, 0, off);
            end else if (choice < 12) begin
                append_instr(KIND_SW, 0, 1, rs2, off);
            end else if (choice < 14 && prog_len < PROG_LEN - 2) begin
                append_instr(KIND_LW, rd, 1, 0, off);   // Load-use pair
                append_instr(KIND_SW, 0, 1, rd, 12'(4 * pick_below(16)));
            end else if (choice == 14) begin
                append_instr(KIND_SW, 0, 1, 0, off);    // Stores zero
            end else begin
                append_instr(KIND_BAD, rd, rs1, rs2, 12'($random(seed)));
            end
        end
        append_instr(KIND_SW, 0, 1, 2, '0);             // Closing store marks the end
    endtask

    // ----------------------------------------
    // Bus monitor and memory model
    // ----------------------------------------
    always @(posedge g_clk) begin
        rd_due = 1'b0;
        if (!rst) begin
            if (instr_ret) begin
                retired++;
            end
            if (mem_req && mem_gnt && mem_out.wen) begin
                if (exp_stores.size() == 0) begin
                    report_problem("store granted with no store left in the program");
                end
                head = exp_stores.pop_front();
                assert (mem_out.addr == head.addr)
                    else show_mismatch("store address", head.addr, mem_out.addr);
                assert (mem_out.wdata == head.data)
                    else show_mismatch("store data", head.data, mem_out.wdata);
                assert (mem_out.strb == 4'hf)
                    else show_mismatch("store strobe", 32'hf, 32'(mem_out.strb));
                assert (retired <= head.index)          // Store retires after grant
                    else show_mismatch("retired before store", head.index, retired);
                assert (retired + 1 >= int'(head.index))    // All but the last older one
                    else show_mismatch("retired behind store", head.index - 1, retired);
                mem[mem_out.addr] = mem_out.wdata;
            end else if (mem_req && mem_gnt) begin
                rd_due  = 1'b1;
                rd_addr = mem_out.addr;
                if (mem_out.addr[31]) begin             // Instruction fetch
                    assert (mem_out.addr == next_fetch)
                        else show_mismatch("fetch order", next_fetch, mem_out.addr);
                    next_fetch = next_fetch + 32'd4;
                end else begin
                    assert (mem_out.addr[31:6] == DATA_BASE[31:6] && mem_out.addr[1:0] == 2'b00)
                        else show_mismatch("load address", DATA_BASE, mem_out.addr);
                end
            end
        end
    end

    always @(negedge g_clk) begin
        mem_gnt   = (pick_below(100) < 60) && !rst;     // About 60 percent
        mem_rdata = rd_due ? read_word(rd_addr) : $random(seed);
    end

    // Pending request must not move until granted
    assert property (@(posedge g_clk) disable iff (rst)
        mem_req && !mem_gnt |=> mem_req && $stable(mem_out))
        else report_problem("bus request changed while waiting for grant");

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------
    initial begin
        seed       = 32'ha2fa_6366;
        rst        = 1'b1;
        mem_gnt    = 1'b0;
        mem_rdata  = '0;
        rd_due     = 1'b0;
        rd_addr    = '0;
        retired    = 0;
        prog_len   = 0;
        next_fetch = PC_RESET;
        build_program();
        repeat (10) @(negedge g_clk);                   // Ten reset cycles
        assert (!mem_req && !instr_ret)
            else report_problem("mem_req or instr_ret high right after reset");
        rst = 1'b0;
        @(negedge g_clk);
        assert (mem_req)
            else report_problem("no fetch request on the first cycle after reset");
        assert (!mem_out.wen && mem_out.addr == PC_RESET)
            else show_mismatch("first fetch", PC_RESET, mem_out.addr);
        cycles = 0;
        while (retired < PROG_LEN && cycles < TIMEOUT) begin
            @(negedge g_clk);
            cycles++;
        end
        if (retired < PROG_LEN) begin
            report_problem("timeout waiting for the program to retire");
        end else begin
            assert (exp_stores.size() == 0)
                else show_mismatch("stores left at end", 0, exp_stores.size());
            repeat (20) @(negedge g_clk);               // No-op tail must not store
            $display("Result: PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: project.f
rtl/frv_pkg.sv
rtl/frv_fetch.sv
rtl/frv_decode.sv
rtl/frv_execute.sv
rtl/frv_memory.sv
rtl/frv_gprs.sv
rtl/frv_mem_arbiter.sv
rtl/frv_pipeline.sv
tb/frv_pipeline_tb.sv

// File: Bender.yml
package:
  name: frv_pipeline

sources:
  - rtl/frv_pkg.sv
  - rtl/frv_fetch.sv
  - rtl/frv_decode.sv
  - rtl/frv_execute.sv
  - rtl/frv_memory.sv
  - rtl/frv_gprs.sv
  - rtl/frv_mem_arbiter.sv
  - rtl/frv_pipeline.sv
  - target: test
    files:
      - tb/frv_pipeline_tb.sv
